/* bench/core_sva.sv */
`timescale 1ns/1ps

module core_sva (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               ibus_cyc_o,
    input logic               ibus_stb_o,
    input bus_pkg::bus_addr_t ibus_adr_o,
    input logic               ibus_ack_i,
    input logic               dbus_cyc_o,
    input logic               dbus_stb_o,
    input logic               dbus_we_o,
    input bus_pkg::bus_addr_t dbus_adr_o,
    input bus_pkg::bus_data_t dbus_dat_o,
    input logic               dbus_ack_i,
    input logic               halted_o
);

    ibus_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ibus_stb_o |-> ibus_cyc_o) else $error("ibus_stb_o high outside a bus cycle");

    dbus_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dbus_stb_o |-> dbus_cyc_o) else $error("dbus_stb_o high outside a bus cycle");

    // a classic master keeps its request steady until the slave acks.
    ibus_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ibus_stb_o && !ibus_ack_i) |=> (ibus_stb_o && $stable(ibus_adr_o)))
        else $error("ibus request changed before ack");

    dbus_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dbus_stb_o && !dbus_ack_i) |=> (dbus_stb_o && $stable(dbus_adr_o) &&
                                         $stable(dbus_we_o) && $stable(dbus_dat_o)))
        else $error("dbus request changed before ack");

    halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        halted_o |=> halted_o) else $error("halted_o fell without reset");

endmodule

bind core_pipeline core_sva u_sva (.*);

/* bench/core_tb.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module core_tb;
    import isa_pkg::*;
    import bus_pkg::*;

    localparam int unsigned NUM_PROGRAMS = 8;
    localparam int unsigned PROG_LEN     = 24;
    localparam int unsigned BODY_END     = 16;
    localparam int unsigned HALT_TIMEOUT = 2000;
    localparam logic [15:0] DUMP_BASE    = 16'h1080;

    logic        clk_i;
    logic        rst_n_i;
    logic        ibus_cyc_o;
    logic        ibus_stb_o;
    bus_addr_t   ibus_adr_o;
    bus_data_t   ibus_dat_i;
    logic        ibus_ack_i;
    logic        dbus_cyc_o;
    logic        dbus_stb_o;
    logic        dbus_we_o;
    bus_addr_t   dbus_adr_o;
    bus_data_t   dbus_dat_o;
    bus_sel_t    dbus_sel_o;
    bus_data_t   dbus_dat_i;
    logic        dbus_ack_i;
    logic        halted_o;

    bus_data_t   imem [32];
    bus_data_t   dmem [64];
    bus_data_t   model_mem [64];
    bus_addr_t   exp_addr [$];
    bus_data_t   exp_data [$];
    int unsigned exp_count;
    int unsigned stores_seen;
    int unsigned errors;
    int unsigned iwait;
    int unsigned dwait;
    logic [31:0] rng_state;

    core_pipeline UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bus_data_t encode(logic [3:0] op, reg_idx_t rd, reg_idx_t rs1,
                                         reg_idx_t rs2, logic [15:0] imm);
        return {op, rd, rs1, rs2, 3'b000, imm};
    endfunction

    function automatic bus_data_t mem_fill(bus_addr_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC0DE_0000;
    endfunction

    task automatic report_error(string what);
        errors = errors + 1;
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    // r1 to r7 get random values first, since the register file has no reset.
    task automatic build_program();
        int unsigned kind;
        logic [3:0]  op;
        logic [15:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        for (int r = 1; r < `CORE_NREGS; r++) begin
            imem[r - 1] = encode(ADDI, 3'(r), 3'd0, 3'd0, 16'(next_rand()));
        end
        for (int i = `CORE_NREGS - 1; i < BODY_END; i++) begin
            kind = next_rand() % 8;
            rd   = 3'(next_rand());
            rs1  = 3'(next_rand());
            rs2  = 3'(next_rand());
            imm  = 16'(next_rand());
            case (kind)
                0, 1: op = ADD;
                2: op = SUB;
                3: op = ADDI;
                4, 5: begin
                    op  = (kind == 4) ? LW : SW;
                    rs1 = 3'd0;
                    imm = 16'h1000 + 16'(4 * (next_rand() % 16));
                end
                6: begin
                    op  = BNE;
                    imm = 16'(4 * (1 + next_rand() % (BODY_END - i)));
                end
                default: op = 4'(8 + next_rand() % 8);
            endcase
            imem[i] = encode(op, rd, rs1, rs2, imm);
        end
        for (int r = 1; r < `CORE_NREGS; r++) begin
            imem[BODY_END + r - 1] = encode(SW, 3'd0, 3'd0, 3'(r), DUMP_BASE + 16'(4 * r));
        end
        imem[PROG_LEN - 1] = encode(HALT, 3'd0, 3'd0, 3'd0, 16'h0);
        for (int i = PROG_LEN; i < 32; i++) begin
            imem[i] = {HALT, 28'(4 * i)};
        end
    endtask

    // the instruction-level model executes one instruction per step with no pipeline timing.
    task automatic run_model();
        data_word_t  regs [`CORE_NREGS];
        bus_data_t   w;
        bus_addr_t   addr;
        data_word_t  a;
        data_word_t  b;
        data_word_t  imm;
        data_word_t  res;
        logic        wr;
        int unsigned pc;
        for (int r = 0; r < `CORE_NREGS; r++) begin
            regs[r] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        pc = 0;
        while (pc < 32 && imem[pc][31:28] != HALT) begin
            w   = imem[pc];
            a   = regs[w[24:22]];
            b   = regs[w[21:19]];
            imm = {{16{w[15]}}, w[15:0]};
            wr  = 1'b0;
            res = '0;
            pc  = pc + 1;
            case (w[31:28])
                ADD: begin
                    res = a + b;
                    wr  = 1'b1;
                end
                SUB: begin
                    res = a - b;
                    wr  = 1'b1;
                end
                ADDI: begin
                    res = a + imm;
                    wr  = 1'b1;
                end
                LW: begin
                    addr = a + imm;
                    res  = model_mem[addr[7:2]];
                    wr   = 1'b1;
                end
                SW: begin
                    addr = a + imm;
                    model_mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                BNE: begin
                    if (a != b) begin
                        pc = pc - 1 + imm / 4;
                    end
                end
                default: ;
            endcase
            if (wr && w[27:25] != 3'd0) begin
                regs[w[27:25]] = res;
            end
        end
        exp_count = exp_addr.size();
    endtask

    task automatic check_store(bus_addr_t addr, bus_data_t data);
        if (exp_addr.size() == 0) begin
            report_error("data bus write seen after the model ran out of stores");
        end else begin
            if (addr !== exp_addr[0]) begin
                report_error($sformatf("Mismatch dbus_adr_o: got %h expected %h",
                                       addr, exp_addr[0]));
            end
            if (data !== exp_data[0]) begin
                report_error($sformatf("Mismatch dbus_dat_o: got %h expected %h",
                                       data, exp_data[0]));
            end
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            stores_seen = stores_seen + 1;
        end
    endtask

    task automatic check_sel(bus_sel_t sel);
        if (sel !== 4'hF) begin
            report_error($sformatf("Mismatch dbus_sel_o: got %h expected %h", sel, 4'hF));
        end
    endtask

    task automatic check_halt(int unsigned seen);
        if (seen != exp_count) begin
            report_error($sformatf("Mismatch store count at halted_o: got %h expected %h",
                                   seen, exp_count));
        end
    endtask

    task automatic check_idle();
        logic [5:0] got;
        got = {ibus_cyc_o, ibus_stb_o, dbus_cyc_o, dbus_stb_o, dbus_we_o, halted_o};
        if (got !== 6'h00) begin
            report_error($sformatf(
                "Mismatch {ibus_cyc_o,ibus_stb_o,dbus_cyc_o,dbus_stb_o,dbus_we_o,halted_o}: %s",
                $sformatf("got %h expected %h", got, 6'h00)));
        end
    endtask

    // both memory models answer after a random number of wait cycles.
    always @(negedge clk_i) begin
        if (ibus_stb_o && !ibus_ack_i) begin
            if (iwait == 0) begin
                ibus_dat_i = imem[ibus_adr_o[6:2]];
                ibus_ack_i = 1'b1;
                iwait      = next_rand() % 4;
            end else begin
                iwait = iwait - 1;
            end
        end else begin
            ibus_ack_i = 1'b0;
        end
        if (dbus_stb_o && !dbus_ack_i) begin
            if (dwait == 0) begin
                if (dbus_we_o) begin
                    check_sel(dbus_sel_o);
                    check_store(dbus_adr_o, dbus_dat_o);
                    dmem[dbus_adr_o[7:2]] = dbus_dat_o;
                end else begin
                    dbus_dat_i = dmem[dbus_adr_o[7:2]];
                end
                dbus_ack_i = 1'b1;
                dwait      = next_rand() % 4;
            end else begin
                dwait = dwait - 1;
            end
        end else begin
            dbus_ack_i = 1'b0;
        end
        if (halted_o === 1'b1 && dbus_cyc_o === 1'b1) begin
            report_error("a data bus cycle started after halted_o went high");
        end
    end

    initial begin
        int unsigned cycles;
        rst_n_i     = 1'b0;
        ibus_dat_i  = '0;
        ibus_ack_i  = 1'b0;
        dbus_dat_i  = '0;
        dbus_ack_i  = 1'b0;
        rng_state   = 32'd65695;
        errors      = 0;
        stores_seen = 0;
        iwait       = 0;
        dwait       = 0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            @(negedge clk_i);
            rst_n_i = 1'b0;
            build_program();
            for (int i = 0; i < 64; i++) begin
                model_mem[i] = mem_fill(32'h1000 + 32'(4 * i));
                dmem[i]      = model_mem[i];
            end
            run_model();
            stores_seen = 0;
            repeat (3) @(posedge clk_i);
            @(negedge clk_i);
            check_idle();
            rst_n_i = 1'b1;
            cycles  = 0;
            while (halted_o !== 1'b1 && cycles < HALT_TIMEOUT) begin
                @(negedge clk_i);
                cycles = cycles + 1;
            end
            if (halted_o !== 1'b1) begin
                report_error("timeout while waiting for halted_o to rise");
            end
            check_halt(stores_seen);
            repeat (4) @(negedge clk_i);
        end
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hdl/back_end.sv */
`timescale 1ns/1ps

module back_end (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               ex_valid_i,
    input  isa_pkg::issue_t    ex_i,
    output logic               dbus_cyc_o,
    output logic               dbus_stb_o,
    output logic               dbus_we_o,
    output bus_pkg::bus_addr_t dbus_adr_o,
    output bus_pkg::bus_data_t dbus_dat_o,
    output bus_pkg::bus_sel_t  dbus_sel_o,
    input  bus_pkg::bus_data_t dbus_dat_i,
    input  logic               dbus_ack_i,
    output logic               stall_o,
    output logic               redirect_o,
    output bus_pkg::bus_addr_t redirect_pc_o,
    output logic               wb_valid_o,
    output isa_pkg::wb_t       wb_o,
    output logic               halted_o
);
    import isa_pkg::*;
    import bus_pkg::*;

    logic       ex_go;
    logic       is_mem;
    logic       is_store;
    logic       writes_rd;
    logic       mem_ack;
    logic       ack_gap_q;
    logic       halted_q;
    data_word_t alu_res;
    data_word_t eff_addr;

    // once halted the core ignores anything left in execute.
    assign ex_go = ex_valid_i && !halted_q;

    assign is_store  = ex_i.op == SW;
    assign is_mem    = (ex_i.op == LW) || is_store;
    assign writes_rd = ex_i.op inside {ADD, SUB, ADDI, LW};

    always_comb begin
        case (ex_i.op)
            ADD:     alu_res = ex_i.rs1_val + ex_i.rs2_val;
            SUB:     alu_res = ex_i.rs1_val - ex_i.rs2_val;
            ADDI:    alu_res = ex_i.rs1_val + ex_i.imm;
            default: alu_res = '0;
        endcase
    end

    assign eff_addr = ex_i.rs1_val + ex_i.imm;

    // the request is held from the issue register, which stays put while stalled.
    // stb stays low for the cycle after an ack before the next transfer.
    assign dbus_stb_o = ex_go && is_mem && !ack_gap_q;
    assign dbus_cyc_o = dbus_stb_o;
    assign dbus_we_o  = dbus_stb_o && is_store;
    assign dbus_adr_o = eff_addr;
    assign dbus_dat_o = ex_i.rs2_val;
    assign dbus_sel_o = BUS_SEL_WORD;

    assign mem_ack = dbus_stb_o && dbus_ack_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_gap_q <= 1'b0;
        end else begin
            ack_gap_q <= mem_ack;
        end
    end

    // loads and stores hold the pipeline until their ack arrives.
    assign stall_o = ex_go && is_mem && !mem_ack;

    assign redirect_o    = ex_go && (ex_i.op == BNE) && (ex_i.rs1_val != ex_i.rs2_val);
    assign redirect_pc_o = ex_i.pc + ex_i.imm;

    // every finished instruction passes through writeback. The we bit marks a real write.
    assign wb_valid_o = ex_go && !stall_o;

    always_comb begin
        wb_o.rd     = ex_i.rd;
        wb_o.we     = writes_rd;
        wb_o.result = (ex_i.op == LW) ? dbus_dat_i : alu_res;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            halted_q <= 1'b0;
        end else if (ex_go && ex_i.op == HALT) begin
            halted_q <= 1'b1;
        end
    end

    assign halted_o = halted_q;

endmodule

/* hdl/bus_pkg.sv */
package bus_pkg;

    // byte address on either Wishbone bus.
    typedef logic [31:0] bus_addr_t;

    typedef logic [31:0] bus_data_t;

    // one select bit per byte lane.
    typedef logic [3:0] bus_sel_t;

    // only whole words are transferred, so every lane is selected.
    localparam bus_sel_t BUS_SEL_WORD = 4'hF;

endpackage

/* hdl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// width of a data word and of every register.
`define CORE_XLEN 32

// number of architectural registers, r0 included.
`define CORE_NREGS 8

// address of the first instruction fetched after reset.
`define CORE_RESET_PC 32'h0000_0000

// instructions are one word long, so the PC steps by four bytes.
`define CORE_INSTR_BYTES 4

// width of the immediate field in the instruction word.
`define CORE_IMM_W 16

`endif

/* hdl/core_pipeline.sv */
`timescale 1ns/1ps

module core_pipeline (
    input  logic               clk_i,
    input  logic               rst_n_i,
    output logic               ibus_cyc_o,
    output logic               ibus_stb_o,
    output bus_pkg::bus_addr_t ibus_adr_o,
    input  bus_pkg::bus_data_t ibus_dat_i,
    input  logic               ibus_ack_i,
    output logic               dbus_cyc_o,
    output logic               dbus_stb_o,
    output logic               dbus_we_o,
    output bus_pkg::bus_addr_t dbus_adr_o,
    output bus_pkg::bus_data_t dbus_dat_o,
    output bus_pkg::bus_sel_t  dbus_sel_o,
    input  bus_pkg::bus_data_t dbus_dat_i,
    input  logic               dbus_ack_i,
    output logic               halted_o
);
    import isa_pkg::*;
    import bus_pkg::*;

    logic      issue_valid;
    issue_t    issue_d;
    logic      ex_valid;
    issue_t    ex_q;
    logic      stall;
    logic      redirect;
    bus_addr_t redirect_pc;
    logic      wb_valid_d;
    wb_t       wb_d;
    logic      wb_valid_q;
    wb_t       wb_q;

    front_end u_front (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .ibus_cyc_o    ( ibus_cyc_o  ),
        .ibus_stb_o    ( ibus_stb_o  ),
        .ibus_adr_o    ( ibus_adr_o  ),
        .ibus_dat_i    ( ibus_dat_i  ),
        .ibus_ack_i    ( ibus_ack_i  ),
        .stall_i       ( stall       ),
        .redirect_i    ( redirect    ),
        .redirect_pc_i ( redirect_pc ),
        .wb_valid_i    ( wb_valid_q  ),
        .wb_i          ( wb_q        ),
        .issue_valid_o ( issue_valid ),
        .issue_o       ( issue_d     )
    );

    stage_reg #(.payload_t(issue_t)) u_issue_reg (
        .clk_i   ( clk_i       ),
        .rst_n_i ( rst_n_i     ),
        .stall_i ( stall       ),
        .flush_i ( redirect    ),
        .valid_i ( issue_valid ),
        .data_i  ( issue_d     ),
        .valid_o ( ex_valid    ),
        .data_o  ( ex_q        )
    );

    back_end u_back (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .ex_valid_i    ( ex_valid    ),
        .ex_i          ( ex_q        ),
        .dbus_cyc_o    ( dbus_cyc_o  ),
        .dbus_stb_o    ( dbus_stb_o  ),
        .dbus_we_o     ( dbus_we_o   ),
        .dbus_adr_o    ( dbus_adr_o  ),
        .dbus_dat_o    ( dbus_dat_o  ),
        .dbus_sel_o    ( dbus_sel_o  ),
        .dbus_dat_i    ( dbus_dat_i  ),
        .dbus_ack_i    ( dbus_ack_i  ),
        .stall_o       ( stall       ),
        .redirect_o    ( redirect    ),
        .redirect_pc_o ( redirect_pc ),
        .wb_valid_o    ( wb_valid_d  ),
        .wb_o          ( wb_d        ),
        .halted_o      ( halted_o    )
    );

    // writeback never waits, so this stage loads on every edge.
    stage_reg #(.payload_t(wb_t)) u_wb_reg (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .stall_i ( 1'b0       ),
        .flush_i ( 1'b0       ),
        .valid_i ( wb_valid_d ),
        .data_i  ( wb_d       ),
        .valid_o ( wb_valid_q ),
        .data_o  ( wb_q       )
    );

endmodule

/* hdl/front_end.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module front_end (
    input  logic               clk_i,
    input  logic               rst_n_i,
    output logic               ibus_cyc_o,
    output logic               ibus_stb_o,
    output bus_pkg::bus_addr_t ibus_adr_o,
    input  bus_pkg::bus_data_t ibus_dat_i,
    input  logic               ibus_ack_i,
    input  logic               stall_i,
    input  logic               redirect_i,
    input  bus_pkg::bus_addr_t redirect_pc_i,
    input  logic               wb_valid_i,
    input  isa_pkg::wb_t       wb_i,
    output logic               issue_valid_o,
    output isa_pkg::issue_t    issue_o
);
    import isa_pkg::*;
    import bus_pkg::*;

    bus_addr_t              pc_q;
    bus_addr_t              adr_q;
    logic                   stb_q;
    logic                   drop_q;
    logic                   ir_valid_q;
    instr_t                 ir_q;
    bus_addr_t              ir_pc_q;
    logic                   halt_seen_q;
    data_word_t             regs_q [`CORE_NREGS];
    logic [`CORE_NREGS-1:0] busy_q;

    opcode_e                op;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   writes_rd;
    logic                   hazard;
    logic                   issue_fire;
    logic                   fetch_start;
    logic                   fetch_done;

    // unknown opcodes are issued as NOP.
    always_comb begin
        case (ir_q.opcode)
            ADD, SUB, ADDI, LW, SW, BNE, HALT: op = ir_q.opcode;
            default: op = NOP;
        endcase
    end

    assign uses_rs1  = op inside {ADD, SUB, ADDI, LW, SW, BNE};
    assign uses_rs2  = op inside {ADD, SUB, SW, BNE};
    assign writes_rd = (op inside {ADD, SUB, ADDI, LW}) && (ir_q.rd != '0);

    // the rd check keeps two writes to one register from overlapping.
    assign hazard = (uses_rs1 && busy_q[ir_q.rs1]) ||
                    (uses_rs2 && busy_q[ir_q.rs2]) ||
                    (writes_rd && busy_q[ir_q.rd]);

    // nothing issues while a taken branch flushes the issue register.
    assign issue_fire = ir_valid_q && !stall_i && !redirect_i && !hazard;

    assign fetch_done  = stb_q && ibus_ack_i;
    assign fetch_start = !stb_q && !redirect_i && !halt_seen_q &&
                         (!ir_valid_q || (issue_fire && op != HALT));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q        <= `CORE_RESET_PC;
            stb_q       <= 1'b0;
            drop_q      <= 1'b0;
            ir_valid_q  <= 1'b0;
            halt_seen_q <= 1'b0;
        end else begin
            if (fetch_start) begin
                stb_q <= 1'b1;
                pc_q  <= pc_q + `CORE_INSTR_BYTES;
            end else if (fetch_done) begin
                stb_q <= 1'b0;
            end
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end
            // a fetch still waiting for ack is finished and thrown away.
            if (fetch_done) begin
                drop_q <= 1'b0;
            end else if (redirect_i && stb_q) begin
                drop_q <= 1'b1;
            end
            if (redirect_i) begin
                ir_valid_q <= 1'b0;
            end else if (fetch_done && !drop_q) begin
                ir_valid_q <= 1'b1;
            end else if (issue_fire) begin
                ir_valid_q <= 1'b0;
            end
            if (issue_fire && op == HALT) begin
                halt_seen_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_start) begin
            adr_q <= pc_q;
        end
        if (fetch_done) begin
            ir_q    <= ibus_dat_i;
            ir_pc_q <= adr_q;
        end
    end

    assign ibus_cyc_o = stb_q;
    assign ibus_stb_o = stb_q;
    assign ibus_adr_o = adr_q;

    always_ff @(posedge clk_i) begin
        if (wb_valid_i && wb_i.we && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.result;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (wb_valid_i && wb_i.we) begin
                busy_q[wb_i.rd] <= 1'b0;
            end
            if (issue_fire && writes_rd) begin
                busy_q[ir_q.rd] <= 1'b1;
            end
        end
    end

    always_comb begin
        issue_o.op      = op;
        issue_o.rd      = ir_q.rd;
        issue_o.rs1_val = (ir_q.rs1 == '0) ? '0 : regs_q[ir_q.rs1];
        issue_o.rs2_val = (ir_q.rs2 == '0) ? '0 : regs_q[ir_q.rs2];
        issue_o.imm     = {{(`CORE_XLEN-`CORE_IMM_W){ir_q.imm16[`CORE_IMM_W-1]}}, ir_q.imm16};
        issue_o.pc      = ir_pc_q;
    end

    assign issue_valid_o = issue_fire;

endmodule

/* hdl/isa_pkg.sv */
`include "core_macros.svh"

package isa_pkg;

    // opcodes outside this list decode as NOP.
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        ADDI = 4'h3,
        LW   = 4'h4,
        SW   = 4'h5,
        BNE  = 4'h6,
        HALT = 4'h7
    } opcode_e;

    typedef logic [2:0] reg_idx_t;

    typedef logic [`CORE_XLEN-1:0] data_word_t;

    // one instruction word, most significant field first.
    typedef struct packed {
        opcode_e                opcode;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        logic [2:0]             rsvd;
        logic [`CORE_IMM_W-1:0] imm16;
    } instr_t;

    // payload carried from the front end into execute.
    typedef struct packed {
        opcode_e    op;
        reg_idx_t   rd;
        data_word_t rs1_val;
        data_word_t rs2_val;
        data_word_t imm;
        data_word_t pc;
    } issue_t;

    // payload carried from execute back to the register file.
    typedef struct packed {
        reg_idx_t   rd;
        logic       we;
        data_word_t result;
    } wb_t;

endpackage

/* hdl/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // flush wins over stall so a redirect always empties the stage.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide the result from the simulation log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module core_tb -f vlog.f -o core_tb_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/core_tb_sim > sim.log 2>&1
grep -qx "Simulation completed successfully" sim.log && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

/* vlog.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/isa_pkg.sv
hdl/stage_reg.sv
hdl/front_end.sv
hdl/back_end.sv
hdl/core_pipeline.sv
bench/core_sva.sv
bench/core_tb.sv
